/* Makefile */
# Verilator simulation of the fetch front end

VERILATOR ?= verilator
TOP       ?= tb_fetch_frontend
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= Test FAILED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* build.f */
+incdir+hw
hw/fetch_types_pkg.sv
hw/rv_isa_pkg.sv
hw/fetch_lane_if.sv
hw/fetch_pc_gen.sv
hw/fetch_slot_split.sv
hw/sbpu.sv
hw/fetch_group_pack.sv
hw/fetch_frontend.sv
verif/fetch_frontend_properties.sv
verif/tb_fetch_frontend.sv

/* hw/fetch_frontend.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch_frontend
// instruction fetch top: pc generator,
// slot feeder, predictor lanes, drain
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "fetch_settings.svh"

`default_nettype none
`timescale 1ns/10ps

module fetch_frontend (
    input  wire                         clk,
    input  wire                         rst_i,
    input  wire                         redirect_i,     // backend flush
    input  fetch_types_pkg::addr_t      redirect_pc_i,
    output logic                        imem_req_o,     // instruction memory
    output fetch_types_pkg::addr_t      imem_addr_o,
    input  wire                         imem_rvalid_i,
    input  fetch_types_pkg::group_t     imem_rdata_i,
    output logic                        out_valid_o,    // packet to decode
    input  wire                         out_ready_i,
    output fetch_types_pkg::addr_t      out_pc_o,
    output fetch_types_pkg::group_t     out_insts_o,
    output fetch_types_pkg::slot_mask_t out_mask_o
);

    logic                   grp_valid;
    fetch_types_pkg::addr_t grp_pc;
    logic                   pred_redirect;
    fetch_types_pkg::addr_t pred_target_pc;
    logic                   pack_empty;

    fetch_lane_if lane_if [`FETCH_WIDTH] ();         // one per slot

    fetch_pc_gen i_fetch_pc_gen (
        .clk              (clk),
        .rst_i            (rst_i),
        .redirect_i       (redirect_i),
        .redirect_pc_i    (redirect_pc_i),
        .pred_redirect_i  (pred_redirect),
        .pred_target_pc_i (pred_target_pc),
        .pack_empty_i     (pack_empty),
        .imem_rvalid_i    (imem_rvalid_i),
        .imem_req_o       (imem_req_o),
        .imem_addr_o      (imem_addr_o),
        .grp_valid_o      (grp_valid),
        .grp_pc_o         (grp_pc)
    );

    fetch_slot_split i_fetch_slot_split (
        .grp_valid_i (grp_valid),
        .grp_pc_i    (grp_pc),
        .grp_data_i  (imem_rdata_i),                 // raw group from memory
        .lanes       (lane_if)
    );

    for (genvar g = 0; g < `FETCH_WIDTH; g++) begin : g_bpu
        sbpu i_sbpu (
            .lane (lane_if[g])
        );
    end

    fetch_group_pack i_fetch_group_pack (
        .clk              (clk),
        .rst_i            (rst_i),
        .redirect_i       (redirect_i),
        .lanes            (lane_if),
        .pred_redirect_o  (pred_redirect),
        .pred_target_pc_o (pred_target_pc),
        .pack_empty_o     (pack_empty),
        .out_valid_o      (out_valid_o),
        .out_ready_i      (out_ready_i),
        .out_pc_o         (out_pc_o),
        .out_insts_o      (out_insts_o),
        .out_mask_o       (out_mask_o)
    );

endmodule

`default_nettype wire

/* hw/fetch_group_pack.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch_group_pack
// picks the first taken slot, trims the
// mask, registers the packet and steers
// the next fetch on a prediction
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "fetch_settings.svh"

`default_nettype none
`timescale 1ns/10ps

module fetch_group_pack (
    input  wire                         clk,
    input  wire                         rst_i,
    input  wire                         redirect_i,       // backend flush
    fetch_lane_if.drain                 lanes [`FETCH_WIDTH],
    output logic                        pred_redirect_o,  // some slot taken
    output fetch_types_pkg::addr_t      pred_target_pc_o,
    output logic                        pack_empty_o,
    output logic                        out_valid_o,
    input  wire                         out_ready_i,
    output fetch_types_pkg::addr_t      out_pc_o,
    output fetch_types_pkg::group_t     out_insts_o,
    output fetch_types_pkg::slot_mask_t out_mask_o
);

    fetch_types_pkg::slot_mask_t valid_vec;
    fetch_types_pkg::slot_mask_t taken_vec;
    fetch_types_pkg::slot_mask_t keep_vec;            // slots up to first taken
    fetch_types_pkg::slot_mask_t trim_mask;
    fetch_types_pkg::addr_t      pc_arr  [`FETCH_WIDTH];
    fetch_types_pkg::addr_t      tgt_arr [`FETCH_WIDTH];
    fetch_types_pkg::inst_t      inst_arr [`FETCH_WIDTH];
    fetch_types_pkg::group_t     grp_data;
    fetch_types_pkg::slot_idx_t  hit_idx;             // first taken slot
    fetch_types_pkg::slot_idx_t  first_idx;           // first valid slot
    logic                        hit;
    logic                        grp_any;             // group arrived
    logic                        pkt_valid_q;

    for (genvar g = 0; g < `FETCH_WIDTH; g++) begin : g_lane
        assign valid_vec[g] = lanes[g].slot_valid;
        assign taken_vec[g] = lanes[g].pred_taken;
        assign pc_arr[g]    = lanes[g].slot_pc;
        assign tgt_arr[g]   = lanes[g].pred_target;
        assign inst_arr[g]  = lanes[g].slot_inst;
        assign keep_vec[g]  = ~hit | (fetch_types_pkg::slot_idx_t'(g) <= hit_idx);
    end

    // downward scan, lowest index wins
    always_comb begin
        hit       = 1'b0;
        hit_idx   = '0;
        first_idx = '0;
        for (int i = `FETCH_WIDTH - 1; i >= 0; i--) begin
            if (valid_vec[i] && taken_vec[i]) begin
                hit     = 1'b1;
                hit_idx = fetch_types_pkg::slot_idx_t'(i);
            end
            if (valid_vec[i])
                first_idx = fetch_types_pkg::slot_idx_t'(i);
        end
    end

    always_comb begin
        grp_data = '0;
        for (int i = 0; i < `FETCH_WIDTH; i++)
            grp_data[32*i +: 32] = inst_arr[i];       // rebuild, slot 0 low
    end

    assign grp_any          = |valid_vec;
    assign trim_mask        = valid_vec & keep_vec;   // drop shadow of taken slot
    assign pred_redirect_o  = hit;
    assign pred_target_pc_o = tgt_arr[hit_idx];
    assign pack_empty_o     = ~pkt_valid_q;
    assign out_valid_o      = pkt_valid_q;

    always_ff @(posedge clk) begin
        if (rst_i)
            pkt_valid_q <= 1'b0;
        else if (redirect_i)
            pkt_valid_q <= 1'b0;                      // old path gone
        else if (grp_any)
            pkt_valid_q <= 1'b1;                      // only arrives when empty
        else if (out_ready_i)
            pkt_valid_q <= 1'b0;                      // consumed
    end

    // payload, held while waiting for ready
    always_ff @(posedge clk) begin
        if (grp_any && !redirect_i) begin
            out_pc_o    <= pc_arr[first_idx];
            out_insts_o <= grp_data;
            out_mask_o  <= trim_mask;
        end
    end

endmodule

`default_nettype wire

/* hw/fetch_lane_if.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch_lane_if
// one instruction slot: feeder fills it,
// predictor adds its guess, drain reads it
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/10ps

interface fetch_lane_if;

    logic                   slot_valid;   // slot holds a live instruction
    fetch_types_pkg::addr_t slot_pc;      // pc of this slot
    fetch_types_pkg::inst_t slot_inst;    // raw instruction word
    logic                   pred_taken;   // predictor says taken
    fetch_types_pkg::addr_t pred_target;  // predicted target pc

    modport feed (
        output slot_valid, slot_pc, slot_inst
    );

    modport pred (
        input  slot_valid, slot_pc, slot_inst,
        output pred_taken, pred_target
    );

    modport drain (
        input slot_valid, slot_pc, slot_inst, pred_taken, pred_target
    );

endinterface

`default_nettype wire

/* hw/fetch_pc_gen.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch_pc_gen
// pc register and request sequencer for
// instruction memory, one request in flight
// drops responses made stale by a redirect
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "fetch_settings.svh"

`default_nettype none
`timescale 1ns/10ps

module fetch_pc_gen (
    input  wire                     clk,
    input  wire                     rst_i,
    input  wire                     redirect_i,        // backend flush
    input  fetch_types_pkg::addr_t  redirect_pc_i,     // flush target
    input  wire                     pred_redirect_i,   // taken slot in group
    input  fetch_types_pkg::addr_t  pred_target_pc_i,  // its target
    input  wire                     pack_empty_i,      // packet reg free
    input  wire                     imem_rvalid_i,     // response pulse
    output logic                    imem_req_o,        // request pulse
    output fetch_types_pkg::addr_t  imem_addr_o,
    output logic                    grp_valid_o,       // filtered response
    output fetch_types_pkg::addr_t  grp_pc_o           // pc that was requested
);

    localparam fetch_types_pkg::addr_t GRP_BYTES =
        fetch_types_pkg::addr_t'(`FETCH_WIDTH * 4);    // bytes per group

    fetch_types_pkg::fetch_state_t state_q;
    fetch_types_pkg::addr_t        pc_q;               // next or current fetch pc
    fetch_types_pkg::addr_t        seq_pc;             // next aligned group
    logic                          stale_q;            // in-flight rsp is dead
    logic                          rsp_fire;           // response for our request

    assign seq_pc      = (pc_q & ~(GRP_BYTES - 1'b1)) + GRP_BYTES;
    assign rsp_fire    = imem_rvalid_i & (state_q == fetch_types_pkg::FS_WAIT);
    assign grp_valid_o = rsp_fire & ~stale_q;          // swallow stale data
    assign grp_pc_o    = pc_q;                         // unchanged while waiting
    assign imem_addr_o = pc_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q    <= fetch_types_pkg::FS_ISSUE;
            stale_q    <= 1'b0;
            imem_req_o <= 1'b0;
            pc_q       <= `RESET_PC;
        end else begin
            imem_req_o <= 1'b0;                        // single cycle pulse
            case (state_q)
                fetch_types_pkg::FS_ISSUE: begin
                    if (redirect_i) begin
                        pc_q <= redirect_pc_i;         // retarget, issue next cycle
                    end else if (pack_empty_i) begin
                        imem_req_o <= 1'b1;
                        state_q    <= fetch_types_pkg::FS_WAIT;
                    end
                end
                fetch_types_pkg::FS_WAIT: begin
                    if (rsp_fire) begin
                        state_q <= fetch_types_pkg::FS_ISSUE;
                        stale_q <= 1'b0;
                        if (redirect_i)
                            pc_q <= redirect_pc_i;     // flush beats prediction
                        else if (!stale_q)
                            pc_q <= pred_redirect_i ? pred_target_pc_i : seq_pc;
                    end else if (redirect_i) begin
                        stale_q <= 1'b1;               // kill the pending response
                        pc_q    <= redirect_pc_i;
                    end
                end
                default: state_q <= fetch_types_pkg::FS_ISSUE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/fetch_settings.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch front end settings
// group width, address width, boot address
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

`default_nettype none

`define FETCH_WIDTH 4            // instruction slots per fetch group
`define ADDR_WIDTH  32           // pc width in bits
`define RESET_PC    32'h0000_0000 // first fetch address after reset

`default_nettype wire

`endif

/* hw/fetch_slot_split.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch_slot_split
// cuts a fetch group into slots, gives each
// its pc and masks slots below the start
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "fetch_settings.svh"

`default_nettype none
`timescale 1ns/10ps

module fetch_slot_split (
    input  wire                      grp_valid_i,
    input  fetch_types_pkg::addr_t   grp_pc_i,     // may point mid-group
    input  fetch_types_pkg::group_t  grp_data_i,
    fetch_lane_if.feed               lanes [`FETCH_WIDTH]
);

    fetch_types_pkg::slot_idx_t start_idx;         // first live slot
    fetch_types_pkg::addr_t     base_pc;           // group aligned pc

    assign start_idx = grp_pc_i[2 +: $bits(fetch_types_pkg::slot_idx_t)];
    assign base_pc   = grp_pc_i & ~fetch_types_pkg::addr_t'(`FETCH_WIDTH * 4 - 1);

    for (genvar g = 0; g < `FETCH_WIDTH; g++) begin : g_slot
        // slots skipped by a jump into the group stay dead
        assign lanes[g].slot_valid = grp_valid_i &
                                     (fetch_types_pkg::slot_idx_t'(g) >= start_idx);
        assign lanes[g].slot_pc    = base_pc + fetch_types_pkg::addr_t'(4 * g);
        assign lanes[g].slot_inst  = grp_data_i[32*g +: 32]; // slot 0 low word
    end

endmodule

`default_nettype wire

/* hw/fetch_types_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch_types_pkg
// types of the fetch pipeline: addresses,
// instruction words, groups and slot masks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "fetch_settings.svh"

`default_nettype none

package fetch_types_pkg;

    typedef logic [`ADDR_WIDTH-1:0]    addr_t;      // pc or fetch address
    typedef logic [31:0]               inst_t;      // one instruction word

    // slot 0 sits in the low word
    typedef logic [`FETCH_WIDTH*32-1:0] group_t;

    typedef logic [`FETCH_WIDTH-1:0]   slot_mask_t; // one bit per slot
    typedef logic [$clog2(`FETCH_WIDTH)-1:0] slot_idx_t; // slot number

    // pc generator states
    typedef enum logic {
        FS_ISSUE,                                   // send next request
        FS_WAIT                                     // one request in flight
    } fetch_state_t;

endpackage

`default_nettype wire

/* hw/rv_isa_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// rv_isa_pkg
// RISC-V encoding fields and the control
// transfer opcodes seen by the predictor
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package rv_isa_pkg;

    // major opcode, inst[6:0]
    typedef logic [6:0] opcode_t;

    // sign extended immediate, bit 0 always zero for B and J types
    typedef logic [31:0] imm_t;

    // control transfer opcodes
    localparam opcode_t OPC_BRANCH = 7'b1100011; // beq, bne, blt, bge, bltu, bgeu
    localparam opcode_t OPC_JAL    = 7'b1101111; // pc relative jump
    localparam opcode_t OPC_JALR   = 7'b1100111; // register indirect jump

endpackage

`default_nettype wire

/* hw/sbpu.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sbpu
// static branch prediction for one slot:
// backward branches and JAL taken
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/10ps

module sbpu (
    fetch_lane_if.pred lane
);

    rv_isa_pkg::opcode_t    opcode;
    rv_isa_pkg::imm_t       b_imm;      // branch offset
    rv_isa_pkg::imm_t       j_imm;      // jal offset
    logic                   taken;      // before slot valid
    fetch_types_pkg::addr_t target;

    assign opcode = lane.slot_inst[6:0];

    assign b_imm = {{20{lane.slot_inst[31]}}, lane.slot_inst[7],
                    lane.slot_inst[30:25], lane.slot_inst[11:8], 1'b0};
    assign j_imm = {{12{lane.slot_inst[31]}}, lane.slot_inst[19:12],
                    lane.slot_inst[20], lane.slot_inst[30:21], 1'b0};

    always_comb begin
        taken  = 1'b0;
        target = lane.slot_pc + fetch_types_pkg::addr_t'(b_imm);
        case (opcode)
            rv_isa_pkg::OPC_BRANCH: begin
                taken = b_imm[31];                          // backward only, loops
            end
            rv_isa_pkg::OPC_JAL: begin
                taken  = 1'b1;                              // always taken
                target = lane.slot_pc + fetch_types_pkg::addr_t'(j_imm);
            end
            rv_isa_pkg::OPC_JALR: begin
                taken = 1'b0;                               // target in a register
            end
            default: taken = 1'b0;
        endcase
    end

    assign lane.pred_taken  = lane.slot_valid & taken;
    assign lane.pred_target = target;

endmodule

`default_nettype wire

/* verif/fetch_frontend_properties.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch_frontend_properties
// memory handshake, packet hold, reset
// and response-to-packet latency checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/10ps

module fetch_frontend_properties (
    input wire                         clk,
    input wire                         rst_i,
    input wire                         redirect_i,
    input wire                         req_i,        // memory request pulse
    input wire                         rvalid_i,     // memory response pulse
    input wire                         grp_valid_i,  // response that was kept
    input wire                         pkt_valid_i,
    input wire                         pkt_ready_i,
    input fetch_types_pkg::addr_t      pkt_pc_i,
    input fetch_types_pkg::group_t     pkt_insts_i,
    input fetch_types_pkg::slot_mask_t pkt_mask_i
);

    int   fail_cnt = 0;                              // failed checks so far
    logic pending_q;                                 // request still unanswered

    always_ff @(posedge clk) begin
        if (rst_i)
            pending_q <= 1'b0;
        else if (req_i)
            pending_q <= 1'b1;
        else if (rvalid_i)
            pending_q <= 1'b0;
    end

    a_one_outstanding: assert property (@(posedge clk) disable iff (rst_i)
        req_i |-> !pending_q)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("second request while one in flight");
        end

    a_hold: assert property (@(posedge clk) disable iff (rst_i)
        pkt_valid_i && !pkt_ready_i && !redirect_i |=> pkt_valid_i && $stable(pkt_pc_i)
        && $stable(pkt_insts_i) && $stable(pkt_mask_i))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("packet changed under back-pressure");
        end

    a_reset: assert property (@(posedge clk) $past(rst_i) |-> !req_i && !pkt_valid_i)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("outputs active during reset");
        end

    a_latency: assert property (@(posedge clk) disable iff (rst_i)
        grp_valid_i && !redirect_i |=> pkt_valid_i)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("no packet one cycle after response");
        end

endmodule

bind fetch_frontend fetch_frontend_properties i_fetch_frontend_properties (
    .clk         (clk),
    .rst_i       (rst_i),
    .redirect_i  (redirect_i),
    .req_i       (imem_req_o),
    .rvalid_i    (imem_rvalid_i),
    .grp_valid_i (grp_valid),
    .pkt_valid_i (out_valid_o),
    .pkt_ready_i (out_ready_i),
    .pkt_pc_i    (out_pc_o),
    .pkt_insts_i (out_insts_o),
    .pkt_mask_i  (out_mask_o)
);

`default_nettype wire

/* verif/tb_fetch_frontend.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tb_fetch_frontend
// program memory with random latency,
// random ready, redirects and a model of
// the expected packet stream
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "fetch_settings.svh"

`default_nettype none
`timescale 1ns/10ps

module tb_fetch_frontend;

    localparam int PROG_WORDS  = 64;                 // program size, wraps
    localparam int MAX_LAT     = 4;
    localparam int PKT_GOAL    = 50;
    localparam int CYCLE_LIMIT = 2 * PROG_WORDS * MAX_LAT + 200;
    localparam int K_PLAIN     = 0;
    localparam int K_BRANCH    = 1;
    localparam int K_JAL       = 2;
    localparam int K_JALR      = 3;

    logic clk, rst_i, redirect_i, imem_req_o, imem_rvalid_i, out_valid_o, out_ready_i;
    fetch_types_pkg::addr_t      redirect_pc_i, imem_addr_o, out_pc_o;
    fetch_types_pkg::group_t     imem_rdata_i, out_insts_o;
    fetch_types_pkg::slot_mask_t out_mask_o;

    fetch_types_pkg::inst_t prog [PROG_WORDS];
    int                     kind [PROG_WORDS];       // control type per word
    int                     offs [PROG_WORDS];       // pc relative offset
    int                     redir_cycle [3] = '{45, 110, 170};
    fetch_types_pkg::addr_t redir_pc [3] = '{32'h60, 32'hA8, 32'h7C};
    integer                 seed;
    int                     cycle_cnt = 0;
    int                     pkt_cnt = 0;
    int                     flush_pkt = 0;           // packets before the late flush
    int                     lat_left = 0;            // cycles to response
    fetch_types_pkg::addr_t rsp_addr;
    fetch_types_pkg::addr_t exp_pc;                  // pc of next packet
    logic                   first_req_seen = 1'b0;
    logic                   inflight_done = 1'b0;    // redirect hit a request

    fetch_frontend i_fetch_frontend (.*);

    task automatic place_ctrl(input int idx, input int k, input int off);
        logic [12:0] b;
        logic [20:0] j;
        b = 13'(off);
        j = 21'(off);
        kind[idx] = k;
        offs[idx] = off;
        case (k)
            K_BRANCH: prog[idx] = {b[12], b[10:5], 5'd0, 5'd0, 3'b000, b[4:1], b[11], 7'b1100011};
            K_JAL:    prog[idx] = {j[20], j[10:1], j[11], j[19:12], 5'd0, 7'b1101111};
            default:  prog[idx] = {12'd0, 5'd1, 3'b000, 5'd0, 7'b1100111}; // jalr x0, 0(x1)
        endcase
    endtask

    task automatic load_program();
        for (int i = 0; i < PROG_WORDS; i++) begin
            prog[i] = {12'(i * 3 + 1), 5'd1, 3'b000, 5'd1, 7'b0010011}; // addi x1, x1
            kind[i] = K_PLAIN;
            offs[i] = 0;
        end
        place_ctrl(5, K_BRANCH, 8);                  // forward, falls through
        place_ctrl(9, K_JAL, 36);                    // into slot 2 of group 4
        place_ctrl(21, K_BRANCH, -32);               // loop back to word 13
        place_ctrl(22, K_JAL, 40);                   // shadowed by the branch
        place_ctrl(24, K_JALR, 0);                   // never predicted
        place_ctrl(26, K_JAL, -100);                 // back to word 1
        place_ctrl(33, K_BRANCH, -12);               // loop back to word 30
    endtask

    function automatic int word_at(input fetch_types_pkg::addr_t a);
        return int'(a >> 2) & (PROG_WORDS - 1);
    endfunction

    function automatic fetch_types_pkg::group_t read_group(input fetch_types_pkg::addr_t a);
        fetch_types_pkg::group_t g;
        int                      base;
        base = word_at(a) & ~(`FETCH_WIDTH - 1);
        for (int s = 0; s < `FETCH_WIDTH; s++)
            g[32*s +: 32] = prog[base + s];         // slot 0 low word
        return g;
    endfunction

    task automatic check_value(input string name, input fetch_types_pkg::group_t exp,
                               input fetch_types_pkg::group_t act);
        assert (act === exp) else begin
            $display("ERROR %0t %s expected %h got %h", $time, name, exp, act);
            $display("Test FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_packet();
        fetch_types_pkg::addr_t     base, nxt;
        fetch_types_pkg::slot_mask_t mask;
        logic                        stop;
        int                          w;
        base = exp_pc & ~fetch_types_pkg::addr_t'(15);
        nxt  = base + 32'd16;                        // sequential default
        mask = '0;
        stop = 1'b0;
        for (int s = int'(exp_pc[3:2]); s < `FETCH_WIDTH; s++) begin
            w = word_at(base + fetch_types_pkg::addr_t'(4 * s));
            if (!stop) begin
                mask[s] = 1'b1;
                if (kind[w] == K_JAL || (kind[w] == K_BRANCH && offs[w] < 0)) begin
                    stop = 1'b1;                     // first taken slot ends it
                    nxt  = base + fetch_types_pkg::addr_t'(4 * s + offs[w]);
                end
            end
        end
        check_value("out_pc_o", fetch_types_pkg::group_t'(exp_pc),
                    fetch_types_pkg::group_t'(out_pc_o));
        check_value("out_insts_o", read_group(exp_pc), out_insts_o);
        check_value("out_mask_o", fetch_types_pkg::group_t'(mask),
                    fetch_types_pkg::group_t'(out_mask_o));
        exp_pc  = nxt;
        pkt_cnt = pkt_cnt + 1;
    endtask

    task automatic finish_run();
        if (i_fetch_frontend.i_fetch_frontend_properties.fail_cnt == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            $display("Test FAILED");
            $fatal(1, "bound assertion failures");
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;                      // 20 ns period
    end

    initial begin
        seed          = 32'ha9e3de6e;
        exp_pc        = `RESET_PC;
        rst_i         = 1'b1;
        redirect_i    = 1'b0;
        redirect_pc_i = '0;
        imem_rvalid_i = 1'b0;
        imem_rdata_i  = '0;
        out_ready_i   = 1'b0;
        load_program();
        repeat (8) @(posedge clk);
        rst_i <= 1'b0;
    end

    always @(posedge clk) begin
        if (!rst_i) begin
            if (i_fetch_frontend.i_fetch_frontend_properties.fail_cnt != 0) begin
                $display("a bound assertion failed at %0t", $time);
                $display("Test FAILED");
                $fatal(1, "assertion failure");
            end
            if (cycle_cnt > CYCLE_LIMIT) begin
                $display("timeout, only %0d packets after %0d cycles", pkt_cnt, cycle_cnt);
                $display("Test FAILED");
                $fatal(1, "timeout");
            end
            if (out_valid_o && out_ready_i)
                check_packet();                      // handshake before flush
            if (redirect_i)
                exp_pc = redirect_pc_i;
            // memory: capture request, count down, answer once
            imem_rvalid_i <= 1'b0;
            if (imem_req_o) begin
                if (!first_req_seen) begin
                    first_req_seen = 1'b1;
                    check_value("imem_addr_o", fetch_types_pkg::group_t'(`RESET_PC),
                                fetch_types_pkg::group_t'(imem_addr_o));
                    check_value("first request cycle", 1, fetch_types_pkg::group_t'(cycle_cnt));
                end
                rsp_addr = imem_addr_o;
                lat_left = 1 + ($random(seed) & 3);
            end
            if (lat_left > 0) begin
                lat_left = lat_left - 1;
                if (lat_left == 0) begin
                    imem_rvalid_i <= 1'b1;
                    imem_rdata_i  <= read_group(rsp_addr);
                end
            end
            out_ready_i <= (($random(seed) & 3) != 0);   // ready 3 of 4 cycles
            redirect_i  <= 1'b0;
            for (int r = 0; r < 3; r++) begin
                if (cycle_cnt == redir_cycle[r]) begin
                    redirect_i    <= 1'b1;
                    redirect_pc_i <= redir_pc[r];
                end
            end
            if (!inflight_done && cycle_cnt >= 210 && imem_req_o) begin
                inflight_done = 1'b1;                // flush while request pending
                flush_pkt     = pkt_cnt;
                redirect_i    <= 1'b1;
                redirect_pc_i <= 32'h4;
            end
            cycle_cnt = cycle_cnt + 1;
            if (pkt_cnt >= PKT_GOAL && inflight_done && pkt_cnt > flush_pkt)
                finish_run();
        end
    end

endmodule

`default_nettype wire
